//--- mldsa_params_pkg.sv
// ML-DSA decompose arithmetic constants and coefficient types
package mldsa_params_pkg;

    // ======================================================================
    // Field constants for the gamma2 = (q-1)/32 parameter set
    // ======================================================================

    // Prime modulus q of the ML-DSA ring
    localparam logic [22:0] MLDSA_Q = 23'd8380417;

    // Rounding half-range gamma2 = (q-1)/32
    localparam logic [18:0] MLDSA_GAMMA2 = 19'd261888;

    // Coefficient width, wide enough for any value below q
    localparam int REG_SIZE = 23;

    // Signed lowbits width, covers -gamma2 to +gamma2
    localparam int R0_W = 19;

    // Highbits width, 16 buckets for this parameter set
    localparam int R1_W = 4;

    // 2*gamma2 = 523776 = 2^19 - 2^9, used for the shift-and-add multiply
    localparam int GAMMA2X2_SHIFT_HI = 19;
    localparam int GAMMA2X2_SHIFT_LO = 9;

    // ======================================================================
    // Datapath types
    // ======================================================================

    typedef logic [REG_SIZE-1:0] coeff_t;
    typedef logic [R1_W-1:0] r1_t;
    typedef logic signed [R0_W-1:0] r0_t;

endpackage

//--- decompose_ctrl_pkg.sv
// Wishbone register map, opcode and FSM state types of the decompose front end
package decompose_ctrl_pkg;

    // ======================================================================
    // Bus geometry
    // ======================================================================

    // Word address width, eight register slots
    localparam int WB_ADR_W = 3;
    localparam int WB_DATA_W = 32;

    // ======================================================================
    // Register map, word indices
    // ======================================================================

    // Coefficient r, read/write, low 23 bits
    localparam logic [WB_ADR_W-1:0] ADDR_COEFF = 3'd0;
    // Hint bit, read/write, bit 0
    localparam logic [WB_ADR_W-1:0] ADDR_HINT = 3'd1;
    // Opcode and start, write-only, reads as zero
    localparam logic [WB_ADR_W-1:0] ADDR_CTRL = 3'd2;
    // Busy, done and corner flags, read-only
    localparam logic [WB_ADR_W-1:0] ADDR_STATUS = 3'd3;
    // Captured highbits, read-only
    localparam logic [WB_ADR_W-1:0] ADDR_R1 = 3'd4;
    // Captured lowbits, sign-extended, read-only
    localparam logic [WB_ADR_W-1:0] ADDR_R0 = 3'd5;

    // Bit positions inside CTRL and STATUS
    localparam int CTRL_OP_BIT = 0;
    localparam int CTRL_START_BIT = 4;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;
    localparam int STATUS_CORNER_BIT = 2;

    // Operation selected by CTRL bit 0
    typedef enum logic {
        OP_DECOMPOSE = 1'b0,
        OP_USE_HINT  = 1'b1
    } decomp_op_e;

    // Operation sequencing states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_CALC    = 2'd1,
        ST_CAPTURE = 2'd2
    } ctrl_state_e;

endpackage

//--- decompose_r1_lut.sv
// Highbits lookup that maps coefficient r to r1 and flags the corner range
`timescale 1ns/1ps

module decompose_r1_lut #(
    parameter int REG_SIZE = mldsa_params_pkg::REG_SIZE
) (
    input  logic [REG_SIZE-1:0] r,
    output logic [3:0]          r1,
    // High when r lies above 31*gamma2 and wraps to r1 = 0
    output logic                r_corner,
    output logic                z_nez
);

    // ======================================================================
    // Threshold search
    // ======================================================================

    // Bucket i covers ((2i-1)*gamma2, (2i+1)*gamma2], so bound i is the
    // odd multiple (2i+1)*gamma2 and r1 is the first bound not exceeded
    function automatic logic [31:0] bound(input int idx);
        logic [31:0] g2;
        g2 = 32'(mldsa_params_pkg::MLDSA_GAMMA2);
        return (2 * idx + 1) * g2;
    endfunction

    // Walking downward leaves the smallest matching index in r1
    // If no bound holds, r sits in the corner range above 31*gamma2
    always_comb begin
        r1 = 4'd0;
        r_corner = 1'b1;
        for (int i = 15; i >= 0; i--) begin
            if (32'(r) <= bound(i)) begin
                r1 = 4'(i);
                r_corner = 1'b0;
            end
        end
    end

    // Nonzero highbits indicator, useful to downstream packing logic
    assign z_nez = (r1 != 4'd0);

endmodule

//--- decompose_r0_calc.sv
// Centered lowbits calculator r0 = r - r1*2*gamma2, or r - q in the corner range
`timescale 1ns/1ps

module decompose_r0_calc (
    input  mldsa_params_pkg::coeff_t r,
    input  mldsa_params_pkg::r1_t    r1,
    input  logic                     r_corner,
    output mldsa_params_pkg::r0_t    r0
);

    // One guard bit above the coefficient width holds the signed difference
    localparam int DIFF_W = mldsa_params_pkg::REG_SIZE + 1;

    logic [DIFF_W-1:0]        r_ext;
    logic [DIFF_W-1:0]        r1_prod;
    logic [DIFF_W-1:0]        sub_val;
    logic signed [DIFF_W-1:0] diff;

    // ======================================================================
    // Shift-and-add multiply by 2*gamma2
    // ======================================================================

    // 523776 = 2^19 - 2^9, so the product is two shifts and one subtract
    // The largest product, 15*523776, still fits below 2^23
    always_comb begin
        r_ext = DIFF_W'(r);
        r1_prod = (DIFF_W'(r1) << mldsa_params_pkg::GAMMA2X2_SHIFT_HI)
                - (DIFF_W'(r1) << mldsa_params_pkg::GAMMA2X2_SHIFT_LO);
    end

    // ======================================================================
    // Centering subtract
    // ======================================================================

    // In the corner range r1 was forced to zero, and subtracting q moves r
    // into -gamma2 .. -1 instead
    always_comb begin
        sub_val = r_corner ? DIFF_W'(mldsa_params_pkg::MLDSA_Q) : r1_prod;
        diff = $signed(r_ext - sub_val);
    end

    // The centered result always fits in R0_W signed bits, top bits drop
    assign r0 = diff[mldsa_params_pkg::R0_W-1:0];

    // Range guard across the LUT and this block together, since a wrong
    // bucket from the LUT would push r0 outside the centered window
    always_comb begin
        assert final (int'(r0) <= int'(mldsa_params_pkg::MLDSA_GAMMA2) &&
                      int'(r0) >= -int'(mldsa_params_pkg::MLDSA_GAMMA2))
            else $error("r0 outside +/- gamma2");
    end

endmodule

//--- use_hint_adjust.sv
// UseHint rule that moves r1 one bucket up or down, modulo 16
`timescale 1ns/1ps

module use_hint_adjust (
    input  mldsa_params_pkg::r1_t r1,
    input  mldsa_params_pkg::r0_t r0,
    input  logic                  hint,
    output mldsa_params_pkg::r1_t r1_hint
);

    // Neighbouring buckets, the 4-bit width gives the mod-16 wrap for free
    mldsa_params_pkg::r1_t r1_up;
    mldsa_params_pkg::r1_t r1_down;

    // Positive lowbits means r sits in the upper half of its bucket
    logic r0_pos;

    always_comb begin
        r1_up = r1 + 4'd1;
        r1_down = r1 - 4'd1;
        r0_pos = (r0 > 0);
    end

    // ======================================================================
    // Hint selection
    // ======================================================================

    // Without a hint the decompose result stands unchanged
    // With a hint, r0 > 0 steps up and r0 <= 0 steps down
    always_comb begin
        if (!hint) begin
            r1_hint = r1;
        end else if (r0_pos) begin
            r1_hint = r1_up;
        end else begin
            r1_hint = r1_down;
        end
    end

endmodule

//--- decompose_wb_regs.sv
// Wishbone classic slave with operand registers, operation FSM and result capture
`timescale 1ns/1ps

module decompose_wb_regs (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       wb_cyc,
    input  logic                                       wb_stb,
    input  logic                                       wb_we,
    input  logic [decompose_ctrl_pkg::WB_ADR_W-1:0]    wb_adr,
    input  logic [decompose_ctrl_pkg::WB_DATA_W-1:0]   wb_wdata,
    output logic [decompose_ctrl_pkg::WB_DATA_W-1:0]   wb_rdata,
    output logic                                       wb_ack,
    output mldsa_params_pkg::coeff_t                   coeff,
    output logic                                       hint,
    input  mldsa_params_pkg::r1_t                      r1,
    input  mldsa_params_pkg::r1_t                      r1_hint,
    input  mldsa_params_pkg::r0_t                      r0,
    input  logic                                       r_corner
);

    localparam int DW = decompose_ctrl_pkg::WB_DATA_W;
    localparam int CW = mldsa_params_pkg::REG_SIZE;
    localparam int R0W = mldsa_params_pkg::R0_W;

    logic                            wb_req;
    logic                            wr_en;
    logic                            wr_coeff;
    logic                            wr_hint;
    logic                            wr_ctrl;
    logic                            start_req;
    logic                            capture;
    logic                            busy;
    logic                            done;
    logic [DW-1:0]                   rd_word;
    mldsa_params_pkg::coeff_t        coeff_q;
    logic                            hint_q;
    decompose_ctrl_pkg::decomp_op_e  op_q;
    decompose_ctrl_pkg::ctrl_state_e state_q;
    decompose_ctrl_pkg::ctrl_state_e state_d;
    mldsa_params_pkg::r1_t           res_r1;
    mldsa_params_pkg::r0_t           res_r0;
    logic                            res_corner;

    // ======================================================================
    // Bus decode
    // ======================================================================

    // A new request is one not already being acknowledged, so back-to-back
    // strobes complete every other cycle
    assign wb_req = wb_cyc && wb_stb && !wb_ack;
    assign wr_en = wb_req && wb_we;
    assign wr_coeff = wr_en && (wb_adr == decompose_ctrl_pkg::ADDR_COEFF);
    assign wr_hint = wr_en && (wb_adr == decompose_ctrl_pkg::ADDR_HINT);
    assign wr_ctrl = wr_en && (wb_adr == decompose_ctrl_pkg::ADDR_CTRL);

    // Start only counts while idle, a start during an operation is dropped
    assign start_req = wr_ctrl && wb_wdata[decompose_ctrl_pkg::CTRL_START_BIT]
                    && (state_q == decompose_ctrl_pkg::ST_IDLE);
    assign busy = (state_q != decompose_ctrl_pkg::ST_IDLE);
    assign capture = (state_q == decompose_ctrl_pkg::ST_CAPTURE);

    // Read mux, CTRL and unmapped slots return zero
    always_comb begin
        rd_word = '0;
        case (wb_adr)
            decompose_ctrl_pkg::ADDR_COEFF: rd_word[CW-1:0] = coeff_q;
            decompose_ctrl_pkg::ADDR_HINT:  rd_word[0] = hint_q;
            decompose_ctrl_pkg::ADDR_STATUS: begin
                rd_word[decompose_ctrl_pkg::STATUS_BUSY_BIT] = busy;
                rd_word[decompose_ctrl_pkg::STATUS_DONE_BIT] = done;
                rd_word[decompose_ctrl_pkg::STATUS_CORNER_BIT] = res_corner;
            end
            decompose_ctrl_pkg::ADDR_R1: rd_word[3:0] = res_r1;
            decompose_ctrl_pkg::ADDR_R0: rd_word = {{(DW-R0W){res_r0[R0W-1]}}, res_r0};
            default: rd_word = '0;
        endcase
    end

    // Ack and read data share the request edge, so rdata is stable with ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            wb_rdata <= '0;
        end else begin
            wb_ack <= wb_req;
            if (wb_req && !wb_we) begin
                wb_rdata <= rd_word;
            end
        end
    end

    // ======================================================================
    // Operand registers
    // ======================================================================

    // Writes land on the same edge that raises ack
    // The opcode only changes while no operation is running
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coeff_q <= '0;
            hint_q <= 1'b0;
            op_q <= decompose_ctrl_pkg::OP_DECOMPOSE;
        end else begin
            if (wr_coeff) coeff_q <= wb_wdata[CW-1:0];
            if (wr_hint) hint_q <= wb_wdata[0];
            if (wr_ctrl && !busy) begin
                op_q <= decompose_ctrl_pkg::decomp_op_e'(
                            wb_wdata[decompose_ctrl_pkg::CTRL_OP_BIT]);
            end
        end
    end

    assign coeff = coeff_q;
    assign hint = hint_q;

    // ======================================================================
    // Operation FSM
    // ======================================================================

    // IDLE -> CALC on start, CALC gives the operand path a settle cycle,
    // CAPTURE stores the results and returns to IDLE
    always_comb begin
        state_d = state_q;
        case (state_q)
            decompose_ctrl_pkg::ST_IDLE:    if (start_req) state_d = decompose_ctrl_pkg::ST_CALC;
            decompose_ctrl_pkg::ST_CALC:    state_d = decompose_ctrl_pkg::ST_CAPTURE;
            decompose_ctrl_pkg::ST_CAPTURE: state_d = decompose_ctrl_pkg::ST_IDLE;
            default:                        state_d = decompose_ctrl_pkg::ST_IDLE;
        endcase
    end

    // Done clears on a new start or a new operand, and is set at capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= decompose_ctrl_pkg::ST_IDLE;
            done <= 1'b0;
        end else begin
            state_q <= state_d;
            if (capture) begin
                done <= 1'b1;
            end else if (start_req || wr_coeff || wr_hint) begin
                done <= 1'b0;
            end
        end
    end

    // Result capture, r1 source chosen by the latched opcode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_r1 <= '0;
            res_r0 <= '0;
            res_corner <= 1'b0;
        end else if (capture) begin
            res_r1 <= (op_q == decompose_ctrl_pkg::OP_USE_HINT) ? r1_hint : r1;
            res_r0 <= r0;
            res_corner <= r_corner;
        end
    end

    // ======================================================================
    // Protocol and sequencing checks
    // ======================================================================

    // Ack answers a strobe seen on the previous edge
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb));

    // Ack is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

    // An operation in flight never reports a stale done
    assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done));

endmodule

//--- mldsa_decompose_top.sv
// ML-DSA decompose accelerator top, Wishbone registers around the combinational datapath
`timescale 1ns/1ps

module mldsa_decompose_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     wb_cyc,
    input  logic                                     wb_stb,
    input  logic                                     wb_we,
    input  logic [decompose_ctrl_pkg::WB_ADR_W-1:0]  wb_adr,
    input  logic [decompose_ctrl_pkg::WB_DATA_W-1:0] wb_wdata,
    output logic [decompose_ctrl_pkg::WB_DATA_W-1:0] wb_rdata,
    output logic                                     wb_ack
);

    // Operands from the register block
    mldsa_params_pkg::coeff_t coeff;
    logic                     hint;

    // Datapath results, sampled by the register block at capture
    mldsa_params_pkg::r1_t    r1;
    mldsa_params_pkg::r1_t    r1_hint;
    mldsa_params_pkg::r0_t    r0;
    logic                     r_corner;

    // ======================================================================
    // Bus side
    // ======================================================================

    decompose_wb_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .coeff    (coeff),
        .hint     (hint),
        .r1       (r1),
        .r1_hint  (r1_hint),
        .r0       (r0),
        .r_corner (r_corner)
    );

    // ======================================================================
    // Datapath
    // ======================================================================

    // The nonzero indicator has no consumer in this design
    decompose_r1_lut #(
        .REG_SIZE (mldsa_params_pkg::REG_SIZE)
    ) u_r1_lut (
        .r        (coeff),
        .r1       (r1),
        .r_corner (r_corner),
        .z_nez    ()
    );

    decompose_r0_calc u_r0_calc (
        .r        (coeff),
        .r1       (r1),
        .r_corner (r_corner),
        .r0       (r0)
    );

    use_hint_adjust u_hint (
        .r1      (r1),
        .r0      (r0),
        .hint    (hint),
        .r1_hint (r1_hint)
    );

endmodule

//--- tb_mldsa_decompose.sv
// Self-checking testbench for the ML-DSA decompose accelerator over Wishbone
`timescale 1ns/1ps

module tb_mldsa_decompose;

    localparam int AW = decompose_ctrl_pkg::WB_ADR_W;
    localparam int DW = decompose_ctrl_pkg::WB_DATA_W;
    localparam int ACK_TIMEOUT = 20;
    localparam int POLL_LIMIT = 10;
    localparam int RANDOM_CASES = 200;

    logic          clk;
    logic          rst_n;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    logic [AW-1:0] wb_adr;
    logic [DW-1:0] wb_wdata;
    logic [DW-1:0] wb_rdata;
    logic          wb_ack;

    mldsa_decompose_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    // 100 MHz clock
    always #5 clk = ~clk;

    // ======================================================================
    // Error reporting and compare tasks
    // ======================================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Testbench stopped at first error");
    endtask

    task automatic check_r1(input string name, input mldsa_params_pkg::r1_t exp,
                            input mldsa_params_pkg::r1_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_r0(input string name, input mldsa_params_pkg::r0_t exp,
                            input mldsa_params_pkg::r0_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected 0x%08h, actual 0x%08h", name, exp, act));
        end
    endtask

    // ======================================================================
    // Wishbone master
    // ======================================================================

    // Inputs change 1 ns after the edge and ack and rdata are sampled there too
    task automatic wb_access(input logic we, input logic [AW-1:0] adr,
                             input logic [DW-1:0] wdata, output logic [DW-1:0] rdata);
        int cycles;
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_wdata = wdata;
        cycles = 0;
        @(posedge clk);
        #1;
        while (!wb_ack && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!wb_ack) begin
            abort_run($sformatf("Timeout: no Wishbone ack for access to address %0d", adr));
        end
        rdata = wb_rdata;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input logic [AW-1:0] adr, input logic [DW-1:0] data);
        logic [DW-1:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [AW-1:0] adr, output logic [DW-1:0] data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic poll_done();
        logic [DW-1:0] status;
        int reads;
        status = '0;
        reads = 0;
        while (!status[decompose_ctrl_pkg::STATUS_DONE_BIT] && reads < POLL_LIMIT) begin
            wb_read(decompose_ctrl_pkg::ADDR_STATUS, status);
            reads++;
        end
        if (!status[decompose_ctrl_pkg::STATUS_DONE_BIT]) begin
            abort_run("Timeout: STATUS never showed done after the start write");
        end
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================

    // Decompose as r mod+- 2*gamma2 with the q-1 boundary folded to r1 = 0
    function automatic void model_decompose(input mldsa_params_pkg::coeff_t r,
                                            output mldsa_params_pkg::r1_t r1,
                                            output mldsa_params_pkg::r0_t r0,
                                            output logic corner);
        int g2;
        int q;
        int rr;
        int low;
        g2 = int'(mldsa_params_pkg::MLDSA_GAMMA2);
        q = int'(mldsa_params_pkg::MLDSA_Q);
        rr = int'(r);
        low = rr % (2 * g2);
        if (low > g2) begin
            low = low - 2 * g2;
        end
        corner = ((rr - low) == (q - 1));
        if (corner) begin
            r1 = '0;
            r0 = mldsa_params_pkg::r0_t'(low - 1);
        end else begin
            r1 = mldsa_params_pkg::r1_t'((rr - low) / (2 * g2));
            r0 = mldsa_params_pkg::r0_t'(low);
        end
    endfunction

    function automatic mldsa_params_pkg::r1_t model_use_hint(input mldsa_params_pkg::r1_t r1,
                                                             input mldsa_params_pkg::r0_t r0,
                                                             input logic hint);
        if (!hint) begin
            return r1;
        end
        if (r0 > 0) begin
            return mldsa_params_pkg::r1_t'((int'(r1) + 1) % 16);
        end
        return mldsa_params_pkg::r1_t'((int'(r1) + 15) % 16);
    endfunction

    // ======================================================================
    // Operation sequences
    // ======================================================================

    task automatic run_op(input logic op, input mldsa_params_pkg::coeff_t r, input logic hint,
                          output logic [DW-1:0] r1_word, output logic [DW-1:0] r0_word,
                          output logic [DW-1:0] status_word);
        logic [DW-1:0] ctrl;
        ctrl = (DW'(1) << decompose_ctrl_pkg::CTRL_START_BIT) | DW'(op);
        wb_write(decompose_ctrl_pkg::ADDR_COEFF, DW'(r));
        wb_write(decompose_ctrl_pkg::ADDR_HINT, DW'(hint));
        wb_write(decompose_ctrl_pkg::ADDR_CTRL, ctrl);
        poll_done();
        wb_read(decompose_ctrl_pkg::ADDR_R1, r1_word);
        wb_read(decompose_ctrl_pkg::ADDR_R0, r0_word);
        wb_read(decompose_ctrl_pkg::ADDR_STATUS, status_word);
    endtask

    // R0 must come back sign-extended over the whole 32-bit word
    task automatic check_result(input string name, input mldsa_params_pkg::r1_t exp_r1,
                                input mldsa_params_pkg::r0_t exp_r0, input logic exp_corner,
                                input logic [DW-1:0] r1_word, input logic [DW-1:0] r0_word,
                                input logic [DW-1:0] status_word);
        check_r1({name, " r1"}, exp_r1, mldsa_params_pkg::r1_t'(r1_word[3:0]));
        check_word({name, " r1 word"}, DW'(exp_r1), r1_word);
        check_r0({name, " r0"}, exp_r0,
                 mldsa_params_pkg::r0_t'(r0_word[mldsa_params_pkg::R0_W-1:0]));
        check_word({name, " r0 word"}, DW'(exp_r0), r0_word);
        check_flag({name, " corner"}, exp_corner, status_word[2]);
        check_flag({name, " done"}, 1'b1, status_word[1]);
        check_flag({name, " busy"}, 1'b0, status_word[0]);
    endtask

    task automatic run_file_vectors();
        int fd;
        int n;
        int count;
        int op_i;
        int r_i;
        int hint_i;
        int r1_i;
        int r0_i;
        int corner_i;
        string line;
        logic [DW-1:0] r1_word;
        logic [DW-1:0] r0_word;
        logic [DW-1:0] status_word;
        count = 0;
        fd = $fopen("decompose_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open decompose_vectors.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Comment lines start with a hash and blank lines scan short
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %d %d", op_i, r_i, hint_i, r1_i, r0_i, corner_i);
            if (n != 6) begin
                continue;
            end
            run_op(op_i[0], mldsa_params_pkg::coeff_t'(r_i), hint_i[0],
                   r1_word, r0_word, status_word);
            check_result($sformatf("vector %0d op %0d r %0d", count, op_i, r_i),
                         mldsa_params_pkg::r1_t'(r1_i), mldsa_params_pkg::r0_t'(r0_i),
                         corner_i[0], r1_word, r0_word, status_word);
            count++;
        end
        $fclose(fd);
        if (count == 0) begin
            abort_run("No vectors found in decompose_vectors.txt");
        end
    endtask

    task automatic run_random_cases();
        mldsa_params_pkg::coeff_t r;
        mldsa_params_pkg::r1_t    r1_exp;
        mldsa_params_pkg::r0_t    r0_exp;
        logic                     corner_exp;
        logic                     op;
        logic                     hint;
        logic [DW-1:0]            r1_word;
        logic [DW-1:0]            r0_word;
        logic [DW-1:0]            status_word;
        for (int i = 0; i < RANDOM_CASES; i++) begin
            r = mldsa_params_pkg::coeff_t'($urandom % 32'(mldsa_params_pkg::MLDSA_Q));
            op = 1'($urandom);
            hint = 1'($urandom);
            model_decompose(r, r1_exp, r0_exp, corner_exp);
            if (op == decompose_ctrl_pkg::OP_USE_HINT) begin
                r1_exp = model_use_hint(r1_exp, r0_exp, hint);
            end
            run_op(op, r, hint, r1_word, r0_word, status_word);
            check_result($sformatf("random %0d op %0d r %0d hint %0d", i, op, r, hint),
                         r1_exp, r0_exp, corner_exp, r1_word, r0_word, status_word);
        end
    endtask

    task automatic check_registers();
        logic [DW-1:0]         rd;
        logic [DW-1:0]         r1_word;
        logic [DW-1:0]         r0_word;
        logic [DW-1:0]         status_word;
        mldsa_params_pkg::r1_t r1_exp;
        mldsa_params_pkg::r0_t r0_exp;
        logic                  corner_exp;
        wb_write(decompose_ctrl_pkg::ADDR_COEFF, 32'hFFFF_FFFF);
        wb_read(decompose_ctrl_pkg::ADDR_COEFF, rd);
        check_word("coeff readback masked", 32'h007F_FFFF, rd);
        wb_write(decompose_ctrl_pkg::ADDR_COEFF, 32'd4190208);
        wb_read(decompose_ctrl_pkg::ADDR_COEFF, rd);
        check_word("coeff readback", 32'd4190208, rd);
        wb_write(decompose_ctrl_pkg::ADDR_HINT, 32'h3);
        wb_read(decompose_ctrl_pkg::ADDR_HINT, rd);
        check_word("hint readback", 32'h1, rd);

        // Done stays up after polling until a new operand arrives
        model_decompose(23'd1000000, r1_exp, r0_exp, corner_exp);
        run_op(decompose_ctrl_pkg::OP_DECOMPOSE, 23'd1000000, 1'b1,
               r1_word, r0_word, status_word);
        check_flag("status done after poll", 1'b1, status_word[1]);
        wb_write(decompose_ctrl_pkg::ADDR_COEFF, 32'd1000000);
        wb_read(decompose_ctrl_pkg::ADDR_STATUS, rd);
        check_flag("done cleared by coeff write", 1'b0, rd[1]);

        // Second start lands while the first is still in flight
        wb_write(decompose_ctrl_pkg::ADDR_CTRL, 32'h10);
        wb_write(decompose_ctrl_pkg::ADDR_CTRL, 32'h11);
        poll_done();
        wb_read(decompose_ctrl_pkg::ADDR_R1, rd);
        check_r1("start while busy ignored", r1_exp, mldsa_params_pkg::r1_t'(rd[3:0]));
        wb_read(decompose_ctrl_pkg::ADDR_R0, rd);
        check_word("start while busy r0", DW'(r0_exp), rd);

        // CTRL and unmapped slots still read zero once the registers hold data
        wb_read(decompose_ctrl_pkg::ADDR_CTRL, rd);
        check_word("ctrl reads zero after write", '0, rd);
        wb_read(3'd6, rd);
        check_word("unmapped address 6 after use", '0, rd);
        wb_read(3'd7, rd);
        check_word("unmapped address 7 after use", '0, rd);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        logic [DW-1:0] rd;
        int unsigned   seed_val;
        clk = 1'b0;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_wdata = '0;
        seed_val = $urandom(80751);
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Everything reads zero out of reset including CTRL and unmapped slots
        wb_read(decompose_ctrl_pkg::ADDR_STATUS, rd);
        check_word("reset status", '0, rd);
        wb_read(decompose_ctrl_pkg::ADDR_R1, rd);
        check_word("reset r1", '0, rd);
        wb_read(decompose_ctrl_pkg::ADDR_R0, rd);
        check_word("reset r0", '0, rd);
        wb_read(decompose_ctrl_pkg::ADDR_CTRL, rd);
        check_word("ctrl reads zero", '0, rd);
        wb_read(3'd6, rd);
        check_word("unmapped address 6", '0, rd);
        wb_read(3'd7, rd);
        check_word("unmapped address 7", '0, rd);

        run_file_vectors();
        run_random_cases();
        check_registers();

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- decompose_vectors.txt
# Columns: opcode (0 decompose, 1 usehint), r, hint, expected r1, expected r0, expected corner
# All values decimal, r0 signed
0 0 0 0 0 0
0 261888 0 0 261888 0
0 261889 0 1 -261887 0
0 523776 0 1 0 0
0 785664 0 1 261888 0
0 785665 0 2 -261887 0
0 1000000 0 2 -47552 0
0 4190208 1 8 0 0
0 8118528 0 15 261888 0
0 8118529 0 0 -261888 1
0 8380416 0 0 -1 1
1 1000000 0 2 -47552 0
1 1000000 1 1 -47552 0
1 523777 1 2 1 0
1 523776 1 0 0 0
1 261888 1 1 261888 0
1 8118528 1 0 261888 0
1 0 1 15 0 0
1 7856640 1 14 0 0
1 8380416 1 15 -1 1
1 8118529 0 0 -261888 1
1 8118529 1 15 -261888 1

//--- mldsa_decompose_top.f
mldsa_params_pkg.sv
decompose_ctrl_pkg.sv
decompose_r1_lut.sv
decompose_r0_calc.sv
use_hint_adjust.sv
decompose_wb_regs.sv
mldsa_decompose_top.sv
tb_mldsa_decompose.sv

//--- Bender.yml
package:
  name: mldsa_decompose

sources:
  # Packages first, then datapath, register block and top level
  - files:
      - mldsa_params_pkg.sv
      - decompose_ctrl_pkg.sv
      - decompose_r1_lut.sv
      - decompose_r0_calc.sv
      - use_hint_adjust.sv
      - decompose_wb_regs.sv
      - mldsa_decompose_top.sv
  # Testbench
  - target: test
    files:
      - tb_mldsa_decompose.sv
